/* all.f */
hw/rv_pkg.sv
hw/imm_gen.sv
hw/control.sv
hw/int_regs.sv
hw/int_alu.sv
hw/rv_core.sv
hw/word_ram.sv
hw/rv_system.sv
bench/rv_core_checker.sv
bench/rv_system_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the rv_system testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_system_tb \
   -f all.f --Mdir obj_dir -o rv_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/rv_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -qx "Simulation passed" sim.log; then
   exit 0
fi
exit 1

/* bench/rv_system_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_system_tb;

   localparam int imem_words = 256;
   localparam int dmem_words = 256;
   localparam int addr_bits  = $clog2(imem_words);

   // RV32I major opcodes
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_auipc  = 7'b0010111;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_imm    = 7'b0010011;
   localparam logic [6:0] opc_reg    = 7'b0110011;

   logic                 clk;
   logic                 reset;
   logic                 load_en;
   logic [addr_bits-1:0] load_addr;
   logic [31:0]          load_data;
   wire  [31:0]          pc;
   wire                  store_en;
   wire  [31:0]          store_addr;
   wire  [31:0]          store_data;

   logic [31:0] prog [$];
   logic [31:0] exp_pc [$];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   logic [31:0] next_store;
   logic [31:0] op_a;
   logic [31:0] op_b;
   logic [31:0] neg_v;
   int          n_expected;
   int          cycle_limit;
   int          errors = 0;
   int          stores_seen = 0;
   logic        running = 1'b0;

   rv_system #(
      .imem_words (imem_words),
      .dmem_words (dmem_words)
   ) dut0 (
      .clk        (clk),
      .reset      (reset),
      .load_en    (load_en),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .pc         (pc),
      .store_en   (store_en),
      .store_addr (store_addr),
      .store_data (store_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_reg};
   endfunction

   function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                          input int rd, input int rs1, input logic [31:0] imm);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
   endfunction

   function automatic logic [31:0] sw_word(input int rs2, input int rs1, input logic [31:0] off);
      return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], opc_store};
   endfunction

   function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                          input logic [31:0] off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opc_branch};
   endfunction

   function automatic logic [31:0] u_type(input logic [6:0] op, input int rd,
                                          input logic [19:0] imm);
      return {imm, rd[4:0], op};
   endfunction

   function automatic logic [31:0] j_type(input int rd, input logic [31:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opc_jal};
   endfunction

   // sign fill done by hand
   function automatic logic [31:0] sra_value(input logic [31:0] v, input logic [4:0] s);
      logic [31:0] fill;
      fill = ~(32'hffff_ffff >> s);
      return v[31] ? ((v >> s) | fill) : (v >> s);
   endfunction

   function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] v1,
                                         input logic [31:0] v2);
      case (f3)
         3'd0:    return v1 == v2;
         3'd1:    return v1 != v2;
         3'd4:    return $signed(v1) < $signed(v2);
         3'd5:    return $signed(v1) >= $signed(v2);
         3'd6:    return v1 < v2;
         default: return v1 >= v2;
      endcase
   endfunction

   function automatic logic [31:0] here();
      return 32'(prog.size()) * 32'd4;
   endfunction

   task automatic emit(input logic [31:0] word);
      prog.push_back(word);
   endtask

   // called just before the store itself is emitted
   task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
      exp_pc.push_back(here());
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   // lui/addi pair, upper part rounded for the signed low half
   task automatic load_const(input int rd, input logic [31:0] value);
      logic [31:0] upper;
      upper = (value + 32'h800) >> 12;
      emit(u_type(opc_lui, rd, upper[19:0]));
      emit(i_type(opc_imm, 3'd0, rd, rd, value));
   endtask

   task automatic store_reg(input int rs2, input logic [31:0] value);
      expect_store(next_store, value);
      emit(sw_word(rs2, 0, next_store));
      next_store = next_store + 32'd4;
   endtask

   // marker store in the slot a taken branch skips
   task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2,
                              input logic [31:0] v1, input logic [31:0] v2);
      emit(b_type(f3, rs1, rs2, 32'd8));
      if (!branch_taken(f3, v1, v2)) begin
         expect_store(next_store, op_a);
      end
      emit(sw_word(1, 0, next_store));
      next_store = next_store + 32'd4;
   endtask

   task automatic build_program();
      logic [31:0] at;
      op_a = $urandom;
      op_b = $urandom;
      neg_v = op_a | 32'h8000_0000;
      next_store = 32'h100;
      load_const(1, op_a);
      load_const(2, op_b);
      emit(r_type(7'h00, 3'd0, 3, 1, 2));
      store_reg(3, op_a + op_b);
      emit(r_type(7'h20, 3'd0, 3, 1, 2));
      store_reg(3, op_a - op_b);
      emit(r_type(7'h00, 3'd7, 3, 1, 2));
      store_reg(3, op_a & op_b);
      emit(r_type(7'h00, 3'd6, 3, 1, 2));
      store_reg(3, op_a | op_b);
      emit(r_type(7'h00, 3'd4, 3, 1, 2));
      store_reg(3, op_a ^ op_b);
      emit(r_type(7'h00, 3'd2, 3, 1, 2));
      store_reg(3, 32'($signed(op_a) < $signed(op_b)));
      emit(r_type(7'h00, 3'd3, 3, 1, 2));
      store_reg(3, 32'(op_a < op_b));
      // shift amount is the low 5 bits of x2
      load_const(4, neg_v);
      emit(r_type(7'h00, 3'd1, 3, 4, 2));
      store_reg(3, neg_v << op_b[4:0]);
      emit(r_type(7'h00, 3'd5, 3, 4, 2));
      store_reg(3, neg_v >> op_b[4:0]);
      emit(r_type(7'h20, 3'd5, 3, 4, 2));
      store_reg(3, sra_value(neg_v, op_b[4:0]));
      emit(i_type(opc_imm, 3'd1, 3, 4, 32'd5));
      store_reg(3, neg_v << 5);
      emit(i_type(opc_imm, 3'd5, 3, 4, 32'd13));
      store_reg(3, neg_v >> 13);
      emit(i_type(opc_imm, 3'd5, 3, 4, 32'h40d));
      store_reg(3, sra_value(neg_v, 5'd13));
      // memory round trip
      expect_store(32'h300, op_a);
      emit(sw_word(1, 0, 32'h300));
      emit(i_type(opc_load, 3'd2, 6, 0, 32'h300));
      store_reg(6, op_a);
      // x8 = -1, x9 = 1
      emit(i_type(opc_imm, 3'd0, 8, 0, 32'hffff_ffff));
      emit(i_type(opc_imm, 3'd0, 9, 0, 32'd1));
      branch_case(3'd0, 1, 1, op_a, op_a);
      branch_case(3'd0, 1, 2, op_a, op_b);
      branch_case(3'd1, 1, 2, op_a, op_b);
      branch_case(3'd1, 1, 1, op_a, op_a);
      branch_case(3'd4, 8, 9, 32'hffff_ffff, 32'd1);
      branch_case(3'd6, 8, 9, 32'hffff_ffff, 32'd1);
      branch_case(3'd5, 8, 9, 32'hffff_ffff, 32'd1);
      branch_case(3'd7, 8, 9, 32'hffff_ffff, 32'd1);
      // jal forward, jalr back to the link, then skip over the jalr
      at = here();
      emit(j_type(11, 32'd12));
      store_reg(11, at + 32'd4);
      emit(j_type(0, 32'd8));
      emit(i_type(opc_jalr, 3'd0, 12, 11, 32'd1));
      store_reg(12, at + 32'd16);
      emit(u_type(opc_lui, 13, op_b[31:12]));
      store_reg(13, {op_b[31:12], 12'b0});
      at = here();
      emit(u_type(opc_auipc, 14, 20'h12345));
      store_reg(14, at + 32'h1234_5000);
      emit(i_type(opc_imm, 3'd0, 0, 1, 32'd5));
      store_reg(0, 32'd0);
      emit(j_type(0, 32'd0));
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] got);
      if (got !== expected) begin
         $display("Error %s expected %h got %h", name, expected, got);
         errors++;
      end
   endtask

   // mid-cycle sample of the write that lands on the next rising edge
   always @(negedge clk) begin
      if (!reset && store_en) begin
         if (stores_seen < n_expected) begin
            check_value("pc", exp_pc[stores_seen], pc);
            check_value("store_addr", exp_addr[stores_seen], store_addr);
            check_value("store_data", exp_data[stores_seen], store_data);
         end else begin
            $display("unexpected extra store to address %h", store_addr);
            errors++;
         end
         stores_seen++;
      end
   end

   initial begin
      wait (running);
      repeat (cycle_limit) @(posedge clk);
      $display("timeout: only %0d of %0d stores seen after %0d cycles",
               stores_seen, n_expected, cycle_limit);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      int total;
      reset = 1'b1;
      load_en = 1'b0;
      load_addr = '0;
      load_data = '0;
      void'($urandom(99));
      build_program();
      n_expected = exp_addr.size();
      cycle_limit = (prog.size() + 20) * 2;
      // program goes in while the core is held in reset
      foreach (prog[i]) begin
         @(negedge clk);
         load_en = 1'b1;
         load_addr = addr_bits'(i);
         load_data = prog[i];
      end
      @(negedge clk);
      load_en = 1'b0;
      repeat (10) @(negedge clk);
      reset = 1'b0;
      running = 1'b1;
      wait (stores_seen >= n_expected);
      // the closing jal loop must not store again
      repeat (20) @(negedge clk);
      total = errors + dut0.core0.chk0.fail_count;
      $display("stores checked %0d of %0d, errors %0d", stores_seen, n_expected, total);
      if (total == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* bench/rv_core_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_checker (
   input wire                      clk,
   input wire                      reset,
   input wire [rv_pkg::xlen-1:0]   pc,
   input wire                      dmem_read,
   input wire                      dmem_write,
   input wire                      op_illegal
);
   int fail_count = 0;

   pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else begin
         $error("pc not word aligned: %h", pc);
         fail_count++;
      end

   rw_exclusive: assert property (@(posedge clk) !(dmem_read && dmem_write))
      else begin
         $error("data memory read and write in the same cycle");
         fail_count++;
      end

   // every instruction in the test program is legal
   no_illegal: assert property (@(posedge clk) disable iff (reset) !op_illegal)
      else begin
         $error("illegal instruction at pc %h", pc);
         fail_count++;
      end

   quiet_in_reset: assert property (@(posedge clk) reset |-> !dmem_write)
      else begin
         $error("data memory write while in reset");
         fail_count++;
      end

endmodule

bind rv_core rv_core_checker chk0 (
   .clk        (clk),
   .reset      (reset),
   .pc         (pc),
   .dmem_read  (dmem_read),
   .dmem_write (dmem_write),
   .op_illegal (op_illegal)
);

`default_nettype wire

/* hw/rv_system.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_system #(
   parameter int imem_words = 256,
   parameter int dmem_words = 256
) (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            load_en,
   input  wire  [$clog2(imem_words)-1:0]  load_addr,
   input  wire  [rv_pkg::xlen-1:0]        load_data,
   output logic [rv_pkg::xlen-1:0]        pc,
   output logic                           store_en,
   output logic [rv_pkg::xlen-1:0]        store_addr,
   output logic [rv_pkg::xlen-1:0]        store_data
);
   import rv_pkg::*;

   logic [xlen-1:0] imem_addr;
   logic [xlen-1:0] imem_data;
   logic [xlen-1:0] dmem_rdata;

   // store_* taps the core's data write port
   rv_core core0 (
      .clk        (clk),
      .reset      (reset),
      .imem_addr  (imem_addr),
      .imem_data  (imem_data),
      .dmem_read  (),
      .dmem_write (store_en),
      .dmem_addr  (store_addr),
      .dmem_wdata (store_data),
      .dmem_rdata (dmem_rdata),
      .pc         (pc)
   );

   // program load port
   word_ram #(.words(imem_words)) imem0 (
      .clk   (clk),
      .we    (load_en),
      .waddr (load_addr),
      .wdata (load_data),
      .raddr (imem_addr[$clog2(imem_words)+1:2]),
      .rdata (imem_data)
   );

   word_ram #(.words(dmem_words)) dmem0 (
      .clk   (clk),
      .we    (store_en),
      .waddr (store_addr[$clog2(dmem_words)+1:2]),
      .wdata (store_data),
      .raddr (store_addr[$clog2(dmem_words)+1:2]),
      .rdata (dmem_rdata)
   );

endmodule

`default_nettype wire

/* hw/word_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module word_ram #(
   parameter int words = 256
) (
   input  wire                       clk,
   input  wire                       we,
   input  wire  [$clog2(words)-1:0]  waddr,
   input  wire  [rv_pkg::xlen-1:0]   wdata,
   input  wire  [$clog2(words)-1:0]  raddr,
   output logic [rv_pkg::xlen-1:0]   rdata
);
   import rv_pkg::*;

   logic [xlen-1:0] mem [words];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // read is combinational
   assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* hw/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
   input  wire                      clk,
   input  wire                      reset,
   output logic [rv_pkg::xlen-1:0]  imem_addr,
   input  wire  [rv_pkg::xlen-1:0]  imem_data,
   output logic                     dmem_read,
   output logic                     dmem_write,
   output logic [rv_pkg::xlen-1:0]  dmem_addr,
   output logic [rv_pkg::xlen-1:0]  dmem_wdata,
   input  wire  [rv_pkg::xlen-1:0]  dmem_rdata,
   output logic [rv_pkg::xlen-1:0]  pc
);
   import rv_pkg::*;

   // one word below the first fetch
   localparam logic [xlen-1:0] pc_reset = xlen'(-4);

   logic [xlen-1:0] pc_next;
   logic [xlen-1:0] pc_plus4;
   logic [xlen-1:0] pc_branch;
   logic [xlen-1:0] jalr_sum;
   logic [31:0]     fetch_ins;
   logic [31:0]     ins;
   logic            idle;
   logic [xlen-1:0] imm;
   alu_op_t         alu_op;
   pc_sel_t         pc_sel;
   logic            alu_alt;
   logic            alu_imm;
   logic            alu_a0;
   logic            alu_apc;
   logic            alu_b4;
   logic            reg_wen;
   logic            dmem_reg;
   logic            op_illegal;
   logic [xlen-1:0] rd_wdata;
   logic [xlen-1:0] rs1_rdata;
   logic [xlen-1:0] rs2_rdata;
   logic [xlen-1:0] alu_a;
   logic [xlen-1:0] alu_b;
   logic [xlen-1:0] alu_y;
   logic            alu_zero;

   // imem is read at pc_next, so the word lines up with pc one edge later
   always_ff @(posedge clk) begin
      fetch_ins <= imem_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         idle <= 1'b1;
         pc   <= pc_reset;
      end else begin
         idle <= 1'b0;
         pc   <= pc_next;
      end
   end

   // idle covers the half cycle after reset drops
   assign ins = (reset || idle) ? ins_nop : fetch_ins;

   imm_gen imm0 (
      .ins (ins),
      .imm (imm)
   );

   control ctrl0 (
      .op_code    (ins[6:0]),
      .funct3     (ins[14:12]),
      .funct7     (ins[31:25]),
      .alu_op     (alu_op),
      .alu_alt    (alu_alt),
      .alu_imm    (alu_imm),
      .alu_a0     (alu_a0),
      .alu_apc    (alu_apc),
      .alu_b4     (alu_b4),
      .reg_wen    (reg_wen),
      .dmem_read  (dmem_read),
      .dmem_write (dmem_write),
      .dmem_reg   (dmem_reg),
      .pc_sel     (pc_sel),
      .op_illegal (op_illegal)
   );

   int_regs regs0 (
      .clk       (clk),
      .wen       (reg_wen),
      .rd_addr   (ins[11:7]),
      .rs1_addr  (ins[19:15]),
      .rs2_addr  (ins[24:20]),
      .rd_wdata  (rd_wdata),
      .rs1_rdata (rs1_rdata),
      .rs2_rdata (rs2_rdata)
   );

   assign alu_a = alu_a0 ? '0 : (alu_apc ? pc : rs1_rdata);
   assign alu_b = alu_b4 ? xlen'(4) : (alu_imm ? imm : rs2_rdata);

   int_alu alu0 (
      .op   (alu_op),
      .alt  (alu_alt),
      .a    (alu_a),
      .b    (alu_b),
      .y    (alu_y),
      .zero (alu_zero)
   );

   assign pc_plus4  = pc + xlen'(4);
   assign pc_branch = pc + imm;
   assign jalr_sum  = rs1_rdata + imm;

   always_comb begin
      case (pc_sel)
         pc_bz:   pc_next = alu_zero ? pc_branch : pc_plus4;
         pc_bnz:  pc_next = alu_zero ? pc_plus4 : pc_branch;
         pc_jal:  pc_next = pc_branch;
         pc_jalr: pc_next = {jalr_sum[xlen-1:1], 1'b0};
         default: pc_next = pc_plus4;
      endcase
   end

   assign imem_addr  = pc_next;
   assign dmem_addr  = alu_y;
   assign dmem_wdata = rs2_rdata;
   assign rd_wdata   = dmem_reg ? dmem_rdata : alu_y;

endmodule

`default_nettype wire

/* hw/int_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module int_alu (
   input  var rv_pkg::alu_op_t      op,
   input  wire                      alt,
   input  wire  [rv_pkg::xlen-1:0]  a,
   input  wire  [rv_pkg::xlen-1:0]  b,
   output logic [rv_pkg::xlen-1:0]  y,
   output logic                     zero
);
   import rv_pkg::*;

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb begin
      case (op)
         alu_add:  y = alt ? a - b : a + b;
         alu_sll:  y = a << shamt;
         alu_slt:  y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
         alu_sltu: y = {{(xlen-1){1'b0}}, a < b};
         alu_xor:  y = a ^ b;
         // alt gives sra
         alu_srl:  y = alt ? xlen'($signed(a) >>> shamt) : a >> shamt;
         alu_or:   y = a | b;
         alu_and:  y = a & b;
         default:  y = '0;
      endcase
   end

   assign zero = (y == '0);

endmodule

`default_nettype wire

/* hw/int_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module int_regs (
   input  wire                      clk,
   input  wire                      wen,
   input  wire  [4:0]               rd_addr,
   input  wire  [4:0]               rs1_addr,
   input  wire  [4:0]               rs2_addr,
   input  wire  [rv_pkg::xlen-1:0]  rd_wdata,
   output logic [rv_pkg::xlen-1:0]  rs1_rdata,
   output logic [rv_pkg::xlen-1:0]  rs2_rdata
);
   import rv_pkg::*;

   logic [xlen-1:0] regs [32];

   always_ff @(posedge clk) begin
      if (wen && rd_addr != 5'd0) begin
         regs[rd_addr] <= rd_wdata;
      end
   end

   // x0 never written, reads as zero
   assign rs1_rdata = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
   assign rs2_rdata = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* hw/control.sv */
`timescale 1ns/1ns
`default_nettype none

module control (
   input  wire  [6:0]      op_code,
   input  wire  [2:0]      funct3,
   input  wire  [6:0]      funct7,
   output rv_pkg::alu_op_t alu_op,
   output logic            alu_alt,
   output logic            alu_imm,
   output logic            alu_a0,
   output logic            alu_apc,
   output logic            alu_b4,
   output logic            reg_wen,
   output logic            dmem_read,
   output logic            dmem_write,
   output logic            dmem_reg,
   output rv_pkg::pc_sel_t pc_sel,
   output logic            op_illegal
);
   import rv_pkg::*;

   logic f7_zero;
   logic f7_alt;

   assign f7_zero = (funct7 == 7'b0000000);
   assign f7_alt  = (funct7 == 7'b0100000);

   always_comb begin
      alu_op     = alu_add;
      alu_alt    = 1'b0;
      alu_imm    = 1'b0;
      alu_a0     = 1'b0;
      alu_apc    = 1'b0;
      alu_b4     = 1'b0;
      reg_wen    = 1'b0;
      dmem_read  = 1'b0;
      dmem_write = 1'b0;
      dmem_reg   = 1'b0;
      pc_sel     = pc_4;
      op_illegal = 1'b0;

      case (op_code)
         op_lui: begin
            alu_a0  = 1'b1;
            alu_imm = 1'b1;
            reg_wen = 1'b1;
         end
         op_auipc: begin
            alu_apc = 1'b1;
            alu_imm = 1'b1;
            reg_wen = 1'b1;
         end
         // link value is pc + 4 from the alu
         op_jal: begin
            alu_apc = 1'b1;
            alu_b4  = 1'b1;
            reg_wen = 1'b1;
            pc_sel  = pc_jal;
         end
         op_jalr: begin
            if (funct3 == 3'b000) begin
               alu_apc = 1'b1;
               alu_b4  = 1'b1;
               reg_wen = 1'b1;
               pc_sel  = pc_jalr;
            end else begin
               op_illegal = 1'b1;
            end
         end
         op_branch: begin
            case (funct3)
               3'b000: begin alu_alt = 1'b1; pc_sel = pc_bz;  end
               3'b001: begin alu_alt = 1'b1; pc_sel = pc_bnz; end
               3'b100: begin alu_op = alu_slt;  pc_sel = pc_bnz; end
               3'b101: begin alu_op = alu_slt;  pc_sel = pc_bz;  end
               3'b110: begin alu_op = alu_sltu; pc_sel = pc_bnz; end
               3'b111: begin alu_op = alu_sltu; pc_sel = pc_bz;  end
               default: op_illegal = 1'b1;
            endcase
         end
         // word access only
         op_load: begin
            alu_imm    = 1'b1;
            dmem_read  = (funct3 == 3'b010);
            dmem_reg   = (funct3 == 3'b010);
            reg_wen    = (funct3 == 3'b010);
            op_illegal = (funct3 != 3'b010);
         end
         op_store: begin
            alu_imm    = 1'b1;
            dmem_write = (funct3 == 3'b010);
            op_illegal = (funct3 != 3'b010);
         end
         op_imm: begin
            alu_op  = alu_op_t'(funct3);
            alu_imm = 1'b1;
            if ((funct3 == 3'b001 && !f7_zero) ||
                (funct3 == 3'b101 && !(f7_zero || f7_alt))) begin
               op_illegal = 1'b1;
            end else begin
               alu_alt = (funct3 == 3'b101) && f7_alt;
               reg_wen = 1'b1;
            end
         end
         op_reg: begin
            alu_op = alu_op_t'(funct3);
            if (f7_zero) begin
               reg_wen = 1'b1;
            end else if (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)) begin
               alu_alt = 1'b1;
               reg_wen = 1'b1;
            end else begin
               op_illegal = 1'b1;
            end
         end
         default: op_illegal = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

/* hw/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
   input  wire  [31:0]              ins,
   output logic [rv_pkg::xlen-1:0]  imm
);
   import rv_pkg::*;

   imm_kind_t  kind;
   logic [6:0] op_code;

   assign op_code = ins[6:0];

   always_comb begin
      case (op_code)
         op_imm, op_load, op_jalr: kind = imm_i;
         op_store:                 kind = imm_s;
         op_branch:                kind = imm_b;
         op_lui, op_auipc:         kind = imm_u;
         op_jal:                   kind = imm_j;
         default:                  kind = imm_none;
      endcase
   end

   // sign always comes from ins[31]
   always_comb begin
      case (kind)
         imm_i:   imm = {{20{ins[31]}}, ins[31:20]};
         imm_s:   imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         imm_b:   imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         imm_u:   imm = {ins[31:12], 12'b0};
         imm_j:   imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         default: imm = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/rv_pkg.sv */
`default_nettype none

package rv_pkg;

   localparam int xlen = 32;

   // addi x0,x0,0
   localparam logic [31:0] ins_nop = 32'h0000_0013;

   // major opcodes, ins[6:0]
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_auipc  = 7'b0010111;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_jalr   = 7'b1100111;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_reg    = 7'b0110011;

   typedef enum logic [2:0] {
      imm_i,
      imm_s,
      imm_b,
      imm_u,
      imm_j,
      imm_none
   } imm_kind_t;

   // bz and bnz test the alu result
   typedef enum logic [2:0] {
      pc_4,
      pc_bz,
      pc_bnz,
      pc_jal,
      pc_jalr
   } pc_sel_t;

   // values follow funct3
   typedef enum logic [2:0] {
      alu_add  = 3'b000,
      alu_sll  = 3'b001,
      alu_slt  = 3'b010,
      alu_sltu = 3'b011,
      alu_xor  = 3'b100,
      alu_srl  = 3'b101,
      alu_or   = 3'b110,
      alu_and  = 3'b111
   } alu_op_t;

endpackage

`default_nettype wire
